/* rtl/cpu_cfg_pkg.sv */
// Widths and depths of the core
// Instruction word is opcode over operand, opcode in the upper bits
// Stack depths should be powers of two so the pointers wrap cleanly

package cpu_cfg_pkg;

	// Data path
	localparam int data_w    = 16;

	// Instruction word fields
	localparam int opcode_w  = 7;
	localparam int operand_w = 9;
	localparam int instr_w   = opcode_w + operand_w;

	// Memory address widths
	localparam int iaddr_w   = 9;
	localparam int daddr_w   = 9;

	// I/O port address widths
	localparam int io_in_w   = 2;
	localparam int io_out_w  = 2;

	// Stacks
	localparam int dstack_depth = 8;
	localparam int rstack_depth = 8;

endpackage

/* rtl/cpu_isa_pkg.sv */
// Instruction set and ALU operation codes
// Opcodes are numbered in list order starting at zero, NOP is zero

package cpu_isa_pkg;

	// Instruction opcodes ----------------------
	typedef enum logic [cpu_cfg_pkg::opcode_w-1:0] {
		NOP,
		// Memory and stack
		LOD,
		SET,
		PSH,
		// Arithmetic and logic
		ADD,
		S_ADD,
		AND_OP,
		ORR,
		XOR_OP,
		INV,
		SHL,
		SHR,
		EQU,
		LES,
		// Indirect access
		LDI,
		STI,
		// I/O ports
		INN,
		OUT,
		// Flow control
		JMP,
		JIZ,
		CAL,
		RET
	} opcode_e;

	// ALU operations ---------------------------
	typedef enum logic [3:0] {
		ALU_PASS_A, ALU_PASS_B,
		ALU_ADD, ALU_AND, ALU_OR, ALU_XOR, ALU_INV,
		ALU_SHL, ALU_SHR, ALU_EQU, ALU_LES
	} alu_op_e;

endpackage

/* rtl/lifo_stack.sv */
// Register-array stack, push has priority over pop
// Overflow and underflow wrap silently, depth should be a power of two

`timescale 1ns/100ps

module lifo_stack #(
	parameter int depth = 8,
	parameter int width = 16
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic             pop,
	input  logic [width-1:0] din,
	output logic [width-1:0] top
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

	logic [width-1:0] mem [depth];
	logic [ptr_w-1:0] ptr;

	// Pointer marks the next free slot
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			ptr <= '0;
		else if (push)
			ptr <= ptr + 1'b1;
		else if (pop)
			ptr <= ptr - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[ptr] <= din;
	end

	assign top = mem[ptr - 1'b1];

endmodule

/* rtl/instr_fetch.sv */
// Program counter and redirect for JMP, JIZ, CAL and RET, no delay slot
// Instruction memory read is synchronous, instr follows instr_addr by one clock
// cond is bit 0 of the result of the instruction in execute

`timescale 1ns/100ps

module instr_fetch (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [cpu_cfg_pkg::instr_w-1:0]     instr,
	input  logic                                cond,
	output logic [cpu_cfg_pkg::iaddr_w-1:0]     instr_addr,
	output cpu_isa_pkg::opcode_e                opcode,
	output logic [cpu_cfg_pkg::operand_w-1:0]   operand
);

	logic [cpu_cfg_pkg::iaddr_w-1:0] pc;
	logic [cpu_cfg_pkg::iaddr_w-1:0] ret_top;
	logic [cpu_cfg_pkg::iaddr_w-1:0] target;
	logic                            take;
	logic                            is_cal;
	logic                            is_ret;
	logic                            redirect;

	// Field split ------------------------------
	assign opcode  = cpu_isa_pkg::opcode_e'(instr[cpu_cfg_pkg::instr_w-1:cpu_cfg_pkg::operand_w]);
	assign operand = instr[cpu_cfg_pkg::operand_w-1:0];

	assign is_cal = (opcode == cpu_isa_pkg::CAL);
	assign is_ret = (opcode == cpu_isa_pkg::RET);

	always_comb begin
		case (opcode)
			cpu_isa_pkg::JMP: take = 1'b1;
			cpu_isa_pkg::JIZ: take = ~cond;
			cpu_isa_pkg::CAL: take = 1'b1;
			cpu_isa_pkg::RET: take = 1'b1;
			default:          take = 1'b0;
		endcase
	end

	// Returns come from the stack, everything else from the operand
	assign target   = is_ret ? ret_top : operand[cpu_cfg_pkg::iaddr_w-1:0];
	assign redirect = take & ~rst;

	// Address driven to the ROM this cycle -----
	assign instr_addr = redirect ? target : pc;

	// PC always holds the address after the one just issued
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pc <= '0;
		else
			pc <= instr_addr + 1'b1;
	end

	// Return addresses, the PC at a CAL already points past it
	lifo_stack #(
		.depth (cpu_cfg_pkg::rstack_depth),
		.width (cpu_cfg_pkg::iaddr_w)
	) ret_stack (
		.clk  (clk),
		.rst  (rst),
		.push (is_cal),
		.pop  (is_ret),
		.din  (pc),
		.top  (ret_top)
	);

endmodule

/* rtl/instr_dec.sv */
// Opcode decode, controls registered into the execute stage
// req_in and ldi are fetch-stage decodes, the rest line up with memory data

`timescale 1ns/100ps

module instr_dec (
	input  logic                                clk,
	input  logic                                rst,
	input  cpu_isa_pkg::opcode_e                opcode,
	input  logic [cpu_cfg_pkg::operand_w-1:0]   operand,
	output cpu_isa_pkg::alu_op_e                alu_op,
	output logic                                sel_stack,
	output logic                                sel_io,
	output logic                                dstack_push,
	output logic                                dstack_pop,
	output logic                                wr,
	output logic                                ldi,
	output logic                                sti,
	output logic                                out_en,
	output logic [cpu_cfg_pkg::io_out_w-1:0]    port,
	output logic                                req_in
);

	cpu_isa_pkg::alu_op_e op_d;
	logic stack_d, io_d, push_d, pop_d, wr_d, sti_d, out_d;

	// Fetch-stage strobes
	assign req_in = (opcode == cpu_isa_pkg::INN) & ~rst;
	assign ldi    = (opcode == cpu_isa_pkg::LDI);

	// Next execute controls --------------------
	always_comb begin
		op_d    = cpu_isa_pkg::ALU_PASS_B;
		stack_d = 1'b0;
		io_d    = 1'b0;
		push_d  = 1'b0;
		pop_d   = 1'b0;
		wr_d    = 1'b0;
		sti_d   = 1'b0;
		out_d   = 1'b0;
		case (opcode)
			cpu_isa_pkg::LOD:    op_d = cpu_isa_pkg::ALU_PASS_A;
			cpu_isa_pkg::SET:    wr_d = 1'b1;
			cpu_isa_pkg::PSH:    push_d = 1'b1;
			cpu_isa_pkg::ADD:    op_d = cpu_isa_pkg::ALU_ADD;
			cpu_isa_pkg::AND_OP: op_d = cpu_isa_pkg::ALU_AND;
			cpu_isa_pkg::ORR:    op_d = cpu_isa_pkg::ALU_OR;
			cpu_isa_pkg::XOR_OP: op_d = cpu_isa_pkg::ALU_XOR;
			cpu_isa_pkg::INV:    op_d = cpu_isa_pkg::ALU_INV;
			cpu_isa_pkg::SHL:    op_d = cpu_isa_pkg::ALU_SHL;
			cpu_isa_pkg::SHR:    op_d = cpu_isa_pkg::ALU_SHR;
			cpu_isa_pkg::EQU:    op_d = cpu_isa_pkg::ALU_EQU;
			cpu_isa_pkg::LES:    op_d = cpu_isa_pkg::ALU_LES;
			cpu_isa_pkg::LDI:    op_d = cpu_isa_pkg::ALU_PASS_A;
			cpu_isa_pkg::INN:    io_d = 1'b1;
			cpu_isa_pkg::OUT:    out_d = 1'b1;
			cpu_isa_pkg::S_ADD: begin
				op_d    = cpu_isa_pkg::ALU_ADD;
				stack_d = 1'b1;
				pop_d   = 1'b1;
			end
			cpu_isa_pkg::STI: begin
				wr_d  = 1'b1;
				sti_d = 1'b1;
				pop_d = 1'b1;
			end
			// NOP and jumps keep the accumulator
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			alu_op      <= cpu_isa_pkg::ALU_PASS_B;
			sel_stack   <= 1'b0;
			sel_io      <= 1'b0;
			dstack_push <= 1'b0;
			dstack_pop  <= 1'b0;
			wr          <= 1'b0;
			sti         <= 1'b0;
			out_en      <= 1'b0;
			port        <= '0;
		end else begin
			alu_op      <= op_d;
			sel_stack   <= stack_d;
			sel_io      <= io_d;
			dstack_push <= push_d;
			dstack_pop  <= pop_d;
			wr          <= wr_d;
			sti         <= sti_d;
			out_en      <= out_d;
			port        <= operand[cpu_cfg_pkg::io_out_w-1:0];
		end
	end

endmodule

/* rtl/alu.sv */
// Integer ALU, operand A is stack top or memory, operand B is io_in or acc
// Stack top and io_in are sampled one clock early to meet the memory data
// Shifts are logical, LES compares acc against A as signed

`timescale 1ns/100ps

module alu (
	input  logic                             clk,
	input  cpu_isa_pkg::alu_op_e             alu_op,
	input  logic                             sel_stack,
	input  logic                             sel_io,
	input  logic [cpu_cfg_pkg::data_w-1:0]   mem_data,
	input  logic [cpu_cfg_pkg::data_w-1:0]   stack_top,
	input  logic [cpu_cfg_pkg::data_w-1:0]   acc,
	input  logic [cpu_cfg_pkg::data_w-1:0]   io_in,
	output logic [cpu_cfg_pkg::data_w-1:0]   result
);

	logic [cpu_cfg_pkg::data_w-1:0] stack_q;
	logic [cpu_cfg_pkg::data_w-1:0] io_q;
	logic [cpu_cfg_pkg::data_w-1:0] a;
	logic [cpu_cfg_pkg::data_w-1:0] b;

	always_ff @(posedge clk) begin
		stack_q <= stack_top;
		io_q    <= io_in;
	end

	assign a = sel_stack ? stack_q : mem_data;
	assign b = sel_io ? io_q : acc;

	always_comb begin
		case (alu_op)
			cpu_isa_pkg::ALU_PASS_A: result = a;
			cpu_isa_pkg::ALU_ADD:    result = b + a;
			cpu_isa_pkg::ALU_AND:    result = b & a;
			cpu_isa_pkg::ALU_OR:     result = b | a;
			cpu_isa_pkg::ALU_XOR:    result = b ^ a;
			cpu_isa_pkg::ALU_INV:    result = ~b;
			cpu_isa_pkg::ALU_SHL:    result = b << a;
			cpu_isa_pkg::ALU_SHR:    result = b >> a;
			// Comparisons give 0 or 1
			cpu_isa_pkg::ALU_EQU:    result = {{(cpu_cfg_pkg::data_w-1){1'b0}}, b == a};
			cpu_isa_pkg::ALU_LES:    result = {{(cpu_cfg_pkg::data_w-1){1'b0}},
				$signed(b) < $signed(a)};
			default:                 result = b;
		endcase
	end

endmodule

/* rtl/mem_io_ctrl.sv */
// Data memory addressing and I/O input port address
// LDI adds the forwarded result to the read address in the fetch stage
// STI adds the current stack top to the write address in execute

`timescale 1ns/100ps

module mem_io_ctrl (
	input  logic                                clk,
	input  logic [cpu_cfg_pkg::operand_w-1:0]   operand,
	input  logic [cpu_cfg_pkg::data_w-1:0]      fwd,
	input  logic                                ldi_f,
	input  logic [cpu_cfg_pkg::data_w-1:0]      stack_top,
	input  logic                                sti,
	input  logic                                wr,
	input  logic                                req_in,
	output logic [cpu_cfg_pkg::daddr_w-1:0]     mem_addr_rd,
	output logic [cpu_cfg_pkg::daddr_w-1:0]     mem_addr_wr,
	output logic [cpu_cfg_pkg::io_in_w-1:0]     addr_in
);

	logic [cpu_cfg_pkg::daddr_w-1:0] rd_ofs;
	logic [cpu_cfg_pkg::daddr_w-1:0] wr_base;
	logic [cpu_cfg_pkg::daddr_w-1:0] wr_ofs;

	// Read side, fetch stage -------------------
	assign rd_ofs      = ldi_f ? fwd[cpu_cfg_pkg::daddr_w-1:0] : '0;
	assign mem_addr_rd = operand[cpu_cfg_pkg::daddr_w-1:0] + rd_ofs;

	// Write side, operand of the instruction in execute
	always_ff @(posedge clk) begin
		wr_base <= operand[cpu_cfg_pkg::daddr_w-1:0];
	end

	// Stack offset only on an STI write
	assign wr_ofs      = (wr & sti) ? stack_top[cpu_cfg_pkg::daddr_w-1:0] : '0;
	assign mem_addr_wr = wr_base + wr_ofs;

	// Input port address is held only while requesting
	assign addr_in = req_in ? operand[cpu_cfg_pkg::io_in_w-1:0] : '0;

endmodule

/* rtl/core.sv */
// Two-stage stack and accumulator core, fetch/decode then execute
// Instruction and data memories have synchronous reads, no back-pressure
// Address 0 is presented twice after reset, so it should hold a NOP

`timescale 1ns/100ps

module core (
	input  logic                               clk,
	input  logic                               rst,
	input  logic [cpu_cfg_pkg::instr_w-1:0]    instr,
	output logic [cpu_cfg_pkg::iaddr_w-1:0]    instr_addr,
	output logic                               mem_wr,
	output logic [cpu_cfg_pkg::daddr_w-1:0]    mem_addr_rd,
	output logic [cpu_cfg_pkg::daddr_w-1:0]    mem_addr_wr,
	input  logic [cpu_cfg_pkg::data_w-1:0]     mem_data_rd,
	output logic [cpu_cfg_pkg::data_w-1:0]     mem_data_wr,
	input  logic [cpu_cfg_pkg::data_w-1:0]     io_in,
	output logic                               req_in,
	output logic [cpu_cfg_pkg::io_in_w-1:0]    addr_in,
	output logic                               out_en,
	output logic [cpu_cfg_pkg::io_out_w-1:0]   addr_out
);

	cpu_isa_pkg::opcode_e             opcode;
	logic [cpu_cfg_pkg::operand_w-1:0] operand;
	cpu_isa_pkg::alu_op_e             alu_op;
	logic                             sel_stack, sel_io;
	logic                             dstack_push, dstack_pop;
	logic                             wr, ldi, sti;
	logic [cpu_cfg_pkg::data_w-1:0]   stack_top;
	logic [cpu_cfg_pkg::data_w-1:0]   alu_result;
	logic [cpu_cfg_pkg::data_w-1:0]   acc;

	// Fetch and decode -------------------------
	instr_fetch u_fetch (
		.clk (clk), .rst (rst), .instr (instr), .cond (alu_result[0]),
		.instr_addr (instr_addr), .opcode (opcode), .operand (operand)
	);

	instr_dec u_dec (
		.clk (clk), .rst (rst), .opcode (opcode), .operand (operand),
		.alu_op (alu_op), .sel_stack (sel_stack), .sel_io (sel_io),
		.dstack_push (dstack_push), .dstack_pop (dstack_pop),
		.wr (wr), .ldi (ldi), .sti (sti), .out_en (out_en),
		.port (addr_out), .req_in (req_in)
	);

	// Execute ----------------------------------
	lifo_stack #(
		.depth (cpu_cfg_pkg::dstack_depth),
		.width (cpu_cfg_pkg::data_w)
	) data_stack (
		.clk (clk), .rst (rst), .push (dstack_push), .pop (dstack_pop),
		.din (alu_result), .top (stack_top)
	);

	alu u_alu (
		.clk (clk), .alu_op (alu_op), .sel_stack (sel_stack), .sel_io (sel_io),
		.mem_data (mem_data_rd), .stack_top (stack_top), .acc (acc),
		.io_in (io_in), .result (alu_result)
	);

	mem_io_ctrl u_mem_io (
		.clk (clk), .operand (operand), .fwd (alu_result), .ldi_f (ldi),
		.stack_top (stack_top), .sti (sti), .wr (wr), .req_in (req_in),
		.mem_addr_rd (mem_addr_rd), .mem_addr_wr (mem_addr_wr), .addr_in (addr_in)
	);

	// Accumulator
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			acc <= '0;
		else
			acc <= alu_result;
	end

	assign mem_data_wr = alu_result;
	assign mem_wr      = wr;

endmodule

/* testbench/core_tb.sv */
// Testbench for the two-stage core with behavioral ROM, RAM and input ports
// Every memory write and OUT is checked in order against a queue of expected events
// OUT to port 3 marks the end of a program and is not checked

`timescale 1ns/100ps

module core_tb;

	localparam int run_limit  = 200;
	localparam int max_cycles = 6 * run_limit;

	logic                               clk;
	logic                               rst;
	logic [cpu_cfg_pkg::instr_w-1:0]    instr;
	logic [cpu_cfg_pkg::iaddr_w-1:0]    instr_addr;
	logic                               mem_wr;
	logic [cpu_cfg_pkg::daddr_w-1:0]    mem_addr_rd;
	logic [cpu_cfg_pkg::daddr_w-1:0]    mem_addr_wr;
	logic [cpu_cfg_pkg::data_w-1:0]     mem_data_rd;
	logic [cpu_cfg_pkg::data_w-1:0]     mem_data_wr;
	logic [cpu_cfg_pkg::data_w-1:0]     io_in;
	logic                               req_in;
	logic [cpu_cfg_pkg::io_in_w-1:0]    addr_in;
	logic                               out_en;
	logic [cpu_cfg_pkg::io_out_w-1:0]   addr_out;

	logic [cpu_cfg_pkg::instr_w-1:0] rom [512];
	logic [cpu_cfg_pkg::data_w-1:0]  ram [512];

	// Expected write and OUT events in program order
	logic                            exp_is_out [$];
	logic [cpu_cfg_pkg::daddr_w-1:0] exp_addr [$];
	logic [cpu_cfg_pkg::data_w-1:0]  exp_data [$];

	logic [31:0] seed;
	int          wp;
	int          errors;
	int          tests;
	int          failed;
	int          cycles;

	core dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Memory and port models ------------------
	always @(posedge clk) begin
		instr       <= #1 rom[instr_addr];
		mem_data_rd <= #1 ram[mem_addr_rd];
		if (mem_wr)
			ram[mem_addr_wr] <= mem_data_wr;
	end

	// Port p reads as p times 16'h1111
	assign io_in = addr_in * 16'h1111;

	initial begin
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", max_cycles);
		$display("TEST FAILED");
		$finish;
	end

	function automatic logic [15:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:16];
	endfunction

	// Expected result of a memory operand instruction
	function automatic logic [15:0] alu_model(input cpu_isa_pkg::opcode_e op,
		input logic [15:0] acc, input logic [15:0] m);
		case (op)
			cpu_isa_pkg::ADD:    return acc + m;
			cpu_isa_pkg::AND_OP: return acc & m;
			cpu_isa_pkg::ORR:    return acc | m;
			cpu_isa_pkg::XOR_OP: return acc ^ m;
			cpu_isa_pkg::SHL:    return acc << m;
			cpu_isa_pkg::SHR:    return acc >> m;
			cpu_isa_pkg::EQU:    return (acc == m) ? 16'd1 : 16'd0;
			cpu_isa_pkg::LES:    return ($signed(acc) < $signed(m)) ? 16'd1 : 16'd0;
			default:             return acc;
		endcase
	endfunction

	task automatic emit(input cpu_isa_pkg::opcode_e op, input int k);
		rom[wp] = {op, k[cpu_cfg_pkg::operand_w-1:0]};
		wp++;
	endtask

	task automatic expect_event(input logic is_out, input int addr, input logic [15:0] data);
		exp_is_out.push_back(is_out);
		exp_addr.push_back(addr[cpu_cfg_pkg::daddr_w-1:0]);
		exp_data.push_back(data);
	endtask

	task automatic emit_set(input int addr, input logic [15:0] data);
		emit(cpu_isa_pkg::SET, addr);
		expect_event(1'b0, addr, data);
	endtask

	task automatic emit_out(input int port, input logic [15:0] data);
		emit(cpu_isa_pkg::OUT, port);
		expect_event(1'b1, port, data);
	endtask

	// Event checking ---------------------------
	task automatic check_event(input logic is_out,
		input logic [cpu_cfg_pkg::daddr_w-1:0] addr, input logic [15:0] data);
		logic                            e_out;
		logic [cpu_cfg_pkg::daddr_w-1:0] e_addr;
		logic [15:0]                     e_data;
		assert (exp_addr.size() != 0) else begin
			$display("unexpected %s event with nothing left to match", is_out ? "OUT" : "write");
			errors++;
		end
		if (exp_addr.size() != 0) begin
			e_out  = exp_is_out.pop_front();
			e_addr = exp_addr.pop_front();
			e_data = exp_data.pop_front();
			assert (is_out == e_out) else begin
				$display("expected a %s event but saw the other kind", e_out ? "OUT" : "write");
				errors++;
			end
			assert (addr == e_addr) else begin
				$display("error: %s got %h expected %h", is_out ? "addr_out" : "mem_addr_wr",
					addr, e_addr);
				errors++;
			end
			assert (data == e_data) else begin
				$display("error: mem_data_wr got %h expected %h", data, e_data);
				errors++;
			end
		end
	endtask

	always @(negedge clk) begin
		if (!rst && mem_wr)
			check_event(1'b0, mem_addr_wr, mem_data_wr);
		if (!rst && out_en && addr_out != 2'd3)
			check_event(1'b1, {7'b0, addr_out}, mem_data_wr);
	end

	task automatic check_idle();
		assert (!mem_wr && !out_en && !req_in) else begin
			$display("error: mem_wr %h out_en %h req_in %h expected 0 0 0",
				mem_wr, out_en, req_in);
			errors++;
		end
		assert (instr_addr == '0) else begin
			$display("error: instr_addr got %h expected %h", instr_addr, 9'h0);
			errors++;
		end
	endtask

	// Test sequencing --------------------------
	// Holds the core in reset and clears the ROM so a program can be loaded
	task automatic begin_test();
		int a;
		@(posedge clk);
		#1 rst = 1'b1;
		for (a = 0; a < 512; a++)
			rom[a] = '0;
		wp = 0;
		emit(cpu_isa_pkg::NOP, 0);
	endtask

	task automatic run_program(input string name, input bit check_reset);
		int n;
		int err0;
		int i;
		emit(cpu_isa_pkg::OUT, 3);
		emit(cpu_isa_pkg::JMP, wp);
		err0 = errors;
		for (i = 0; i < 16; i++) begin
			@(negedge clk);
			if (check_reset)
				check_idle();
			@(posedge clk);
		end
		#1 rst = 1'b0;
		// First cycle out of reset still fetches address 0
		if (check_reset) begin
			@(negedge clk);
			check_idle();
		end
		n = 0;
		while (!(out_en && addr_out == 2'd3) && n < run_limit) begin
			@(negedge clk);
			n++;
		end
		assert (n < run_limit) else begin
			$display("%s: program never reached its end marker", name);
			errors++;
		end
		assert (exp_addr.size() == 0) else begin
			$display("%s: %0d expected events never appeared", name, exp_addr.size());
			errors++;
		end
		exp_is_out.delete();
		exp_addr.delete();
		exp_data.delete();
		tests++;
		if (errors != err0)
			failed++;
		$display("test %0d %s: %0d errors", tests, name, errors - err0);
	endtask

	task automatic test_mem_alu();
		cpu_isa_pkg::opcode_e op;
		logic [15:0]          a;
		logic [15:0]          m;
		int                   i;
		begin_test();
		a = next_rand();
		ram[16] = a;
		emit(cpu_isa_pkg::LOD, 16);
		emit_set(64, a);
		emit(cpu_isa_pkg::INV, 0);
		emit_set(65, ~a);
		for (i = 0; i < 6; i++) begin
			case (i)
				0:       op = cpu_isa_pkg::ADD;
				1:       op = cpu_isa_pkg::AND_OP;
				2:       op = cpu_isa_pkg::ORR;
				3:       op = cpu_isa_pkg::XOR_OP;
				4:       op = cpu_isa_pkg::SHL;
				default: op = cpu_isa_pkg::SHR;
			endcase
			a = next_rand();
			m = next_rand();
			// Shift counts stay inside the word
			if (i >= 4)
				m = m & 16'h000f;
			ram[17 + i] = a;
			ram[24 + i] = m;
			emit(cpu_isa_pkg::LOD, 17 + i);
			emit(op, 24 + i);
			emit_set(66 + i, alu_model(op, a, m));
		end
		run_program("memory alu", 1'b0);
	endtask

	task automatic test_compare();
		cpu_isa_pkg::opcode_e op;
		logic [15:0]          x;
		logic [15:0]          y;
		logic [15:0]          r;
		int                   i;
		int                   base;
		begin_test();
		for (i = 0; i < 4; i++) begin
			base = 32 + 2 * i;
			x = next_rand();
			y = next_rand();
			// First pair is equal and the last pair is the third one swapped
			if (i == 0)
				y = x;
			if (i == 3) begin
				x = ram[37];
				y = ram[36];
			end
			if (i < 2)
				op = cpu_isa_pkg::EQU;
			else
				op = cpu_isa_pkg::LES;
			ram[base] = x;
			ram[base + 1] = y;
			r = alu_model(op, x, y);
			emit(cpu_isa_pkg::LOD, base);
			emit(op, base + 1);
			emit(cpu_isa_pkg::JIZ, wp + 3);
			emit(cpu_isa_pkg::OUT, 1);
			emit(cpu_isa_pkg::JMP, wp + 2);
			emit(cpu_isa_pkg::OUT, 2);
			expect_event(1'b1, r[0] ? 1 : 2, r);
		end
		run_program("compare jiz", 1'b0);
	endtask

	task automatic test_stack();
		logic [15:0] v [4];
		logic [15:0] w;
		logic [15:0] o;
		int          i;
		begin_test();
		// The two lower entries become distinct nonzero STI offsets
		v[0] = (next_rand() & 16'h0007) + 16'd1;
		v[1] = (next_rand() & 16'h0007) + 16'd9;
		v[2] = next_rand();
		v[3] = next_rand();
		w = next_rand();
		o = (next_rand() & 16'h000f) + 16'd1;
		for (i = 0; i < 4; i++)
			ram[40 + i] = v[i];
		ram[44] = w;
		ram[45] = o;
		for (i = 0; i < 3; i++) begin
			emit(cpu_isa_pkg::LOD, 40 + i);
			emit(cpu_isa_pkg::PSH, 0);
		end
		emit(cpu_isa_pkg::LOD, 43);
		emit(cpu_isa_pkg::S_ADD, 0);
		emit_set(96, v[2] + v[3]);
		emit(cpu_isa_pkg::LOD, 44);
		emit(cpu_isa_pkg::STI, 100);
		expect_event(1'b0, 100 + v[1], w);
		emit(cpu_isa_pkg::STI, 120);
		expect_event(1'b0, 120 + v[0], w);
		emit(cpu_isa_pkg::LOD, 45);
		emit(cpu_isa_pkg::LDI, 200);
		emit_set(97, ram[200 + o]);
		run_program("stack indirect", 1'b0);
	endtask

	task automatic test_calls();
		int i;
		begin_test();
		for (i = 0; i < 5; i++) begin
			ram[48 + i] = next_rand();
			expect_event(1'b1, 1, ram[48 + i]);
		end
		// Main starts at 1 with the first level at 10 and the nested level at 20
		emit(cpu_isa_pkg::LOD, 48);
		emit(cpu_isa_pkg::OUT, 1);
		emit(cpu_isa_pkg::CAL, 10);
		emit(cpu_isa_pkg::LOD, 52);
		emit(cpu_isa_pkg::OUT, 1);
		wp = 10;
		emit(cpu_isa_pkg::LOD, 49);
		emit(cpu_isa_pkg::OUT, 1);
		emit(cpu_isa_pkg::CAL, 20);
		emit(cpu_isa_pkg::LOD, 51);
		emit(cpu_isa_pkg::OUT, 1);
		emit(cpu_isa_pkg::RET, 0);
		wp = 20;
		emit(cpu_isa_pkg::LOD, 50);
		emit(cpu_isa_pkg::OUT, 1);
		emit(cpu_isa_pkg::RET, 0);
		// End marker goes right after main
		wp = 6;
		run_program("call return", 1'b0);
	endtask

	task automatic test_io();
		int i;
		begin_test();
		for (i = 0; i < 4; i++) begin
			emit(cpu_isa_pkg::INN, i);
			emit_set(140 + i, i * 16'h1111);
			if (i < 3)
				emit_out(i, i * 16'h1111);
		end
		run_program("io ports", 1'b0);
	endtask

	// Main sequence ----------------------------
	initial begin
		int a;
		rst = 1'b1;
		instr = '0;
		mem_data_rd = '0;
		seed = 32'h79e5;
		errors = 0;
		tests = 0;
		failed = 0;
		for (a = 0; a < 512; a++)
			ram[a] = 16'(a * 257) ^ 16'hc3a5;
		begin_test();
		run_program("reset", 1'b1);
		test_mem_alu();
		test_compare();
		test_stack();
		test_calls();
		test_io();
		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* sim.f */
rtl/cpu_cfg_pkg.sv
rtl/cpu_isa_pkg.sv
rtl/lifo_stack.sv
rtl/instr_fetch.sv
rtl/instr_dec.sv
rtl/alu.sv
rtl/mem_io_ctrl.sv
rtl/core.sv
testbench/core_tb.sv
